//--- src.f
logic/core_pkg.sv
logic/reg_file.sv
logic/csr_file.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/writeback_unit.sv
logic/core_backend.sv
test/core_backend_props.sv
test/core_backend_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module core_backend_tb \
  -Mdir obj_dir -o core_backend_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/core_backend_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- test/core_backend_tb.sv
`timescale 1ns/10ps

module core_backend_tb;
  import core_pkg::*;

  logic      clock = 1'b0;
  logic      reset;
  logic      inst_valid;
  word_t     inst;
  word_t     pc;
  logic      inst_ready;
  logic      commit_ready;
  logic      commit_valid;
  word_t     commit_dnpc;
  logic      commit_jump;
  logic      commit_branch;
  reg_addr_t commit_rd;
  logic      rd_we;
  reg_addr_t rd_addr;
  word_t     rd_data;
  logic      csr_we;
  csr_addr_t csr_waddr;
  word_t     csr_wdata;

  // ====================
  // Reference model
  word_t  model_regs [32];
  word_t  model_mtvec;
  word_t  model_mepc;
  word_t  model_mcause;
  word_t  model_mscratch;
  word_t  cur_pc;
  integer seed;
  logic   commit_pending; // Last commit record not yet taken

  // Expected outcome of the instruction in flight
  logic      exp_wb;
  reg_addr_t exp_rd;
  word_t     exp_data;
  logic      exp_csr;
  csr_addr_t exp_caddr;
  word_t     exp_cdata;
  word_t     exp_dnpc;
  logic      exp_jump;
  logic      exp_branch;

  core_backend dut_i (.*);

  always #50 clock = ~clock;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "stopping after first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t want);
    assert (got == want) else begin
      fail_run($sformatf("ERROR %s: got %h, expected %h", name, got, want));
    end
  endtask

  function automatic word_t csr_value(input csr_addr_t addr);
    case (addr)
      CSR_MTVEC:    return model_mtvec;
      CSR_MEPC:     return model_mepc;
      CSR_MCAUSE:   return model_mcause;
      CSR_MSCRATCH: return model_mscratch;
      default:      return '0; // Unknown CSRs read as zero
    endcase
  endfunction

  task automatic csr_write_model(input csr_addr_t addr, input word_t value);
    case (addr)
      CSR_MTVEC:    model_mtvec = value;
      CSR_MEPC:     model_mepc = value;
      CSR_MCAUSE:   model_mcause = value;
      CSR_MSCRATCH: model_mscratch = value;
      default:      ;
    endcase
  endtask

  task automatic set_expect(input logic wb, input reg_addr_t rd, input word_t data,
                            input logic csr, input csr_addr_t caddr, input word_t cdata,
                            input word_t dnpc, input logic jump, input logic branch);
    exp_wb = wb && (rd != '0); // x0 is never written
    exp_rd = rd;
    exp_data = data;
    exp_csr = csr;
    exp_caddr = caddr;
    exp_cdata = cdata;
    exp_dnpc = dnpc;
    exp_jump = jump;
    exp_branch = branch;
  endtask

  task automatic wait_inst_ready();
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (!inst_ready) begin
      if (cycles == 20) fail_run("Timed out waiting for inst_ready to rise");
      cycles++;
      @(negedge clock);
    end
  endtask

  task automatic wait_commit();
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (!commit_valid) begin
      if (cycles == 20) fail_run("Timed out waiting for commit_valid to rise");
      check_word("inst_ready", {31'b0, inst_ready}, 32'd0);
      cycles++;
      @(negedge clock);
    end
  endtask

  // Commit held back for a random stretch while the next offer waits
  task automatic release_commit();
    logic [31:0] rnd;
    rnd = $random(seed);
    repeat (rnd[2:0]) begin // Back-pressure stretch
      @(negedge clock);
      check_word("commit_valid", {31'b0, commit_valid}, 32'd1);
      check_word("inst_ready", {31'b0, inst_ready}, 32'd0);
    end
    @(posedge clock);
    commit_ready <= 1'b1;
    @(posedge clock);
    commit_ready <= 1'b0;
    commit_pending = 1'b0;
  endtask

  // ====================
  // Issue, check and retire one instruction
  task automatic run_inst(input word_t word);
    @(posedge clock);
    inst_valid <= 1'b1;
    inst <= word;
    pc <= cur_pc;
    if (commit_pending) release_commit();
    wait_inst_ready();
    @(posedge clock);
    inst_valid <= 1'b0;
    wait_commit();
    check_word("rd_we", {31'b0, rd_we}, {31'b0, exp_wb});
    if (exp_wb) begin
      check_word("rd_addr", {27'b0, rd_addr}, {27'b0, exp_rd});
      check_word("rd_data", rd_data, exp_data);
    end
    check_word("csr_we", {31'b0, csr_we}, {31'b0, exp_csr});
    if (exp_csr) begin
      check_word("csr_waddr", {20'b0, csr_waddr}, {20'b0, exp_caddr});
      check_word("csr_wdata", csr_wdata, exp_cdata);
    end
    check_word("commit_dnpc", commit_dnpc, exp_dnpc);
    check_word("commit_jump", {31'b0, commit_jump}, {31'b0, exp_jump});
    check_word("commit_branch", {31'b0, commit_branch}, {31'b0, exp_branch});
    check_word("commit_rd", {27'b0, commit_rd}, exp_wb ? {27'b0, exp_rd} : '0);
    if (exp_wb) model_regs[exp_rd] = exp_data;
    if (exp_csr) csr_write_model(exp_caddr, exp_cdata);
    cur_pc = exp_dnpc;
    commit_pending = 1'b1;
  endtask

  task automatic addi_check(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
    set_expect(1'b1, rd, model_regs[rs1] + {{20{imm[11]}}, imm}, 1'b0, '0, '0,
               cur_pc + 32'd4, 1'b0, 1'b0);
    run_inst({imm, rs1, 3'b000, rd, OPC_OP_IMM});
  endtask

  task automatic alu_check(input logic sub, input reg_addr_t rd, input reg_addr_t rs1,
                           input reg_addr_t rs2);
    word_t data;
    data = sub ? model_regs[rs1] - model_regs[rs2] : model_regs[rs1] + model_regs[rs2];
    set_expect(1'b1, rd, data, 1'b0, '0, '0, cur_pc + 32'd4, 1'b0, 1'b0);
    run_inst({1'b0, sub, 5'b0, rs2, rs1, 3'b000, rd, OPC_OP});
  endtask

  task automatic lui_check(input reg_addr_t rd, input logic [19:0] upper);
    set_expect(1'b1, rd, {upper, 12'b0}, 1'b0, '0, '0, cur_pc + 32'd4, 1'b0, 1'b0);
    run_inst({upper, rd, OPC_LUI});
  endtask

  task automatic jal_check(input reg_addr_t rd, input logic [20:0] off);
    set_expect(1'b1, rd, cur_pc + 32'd4, 1'b0, '0, '0, cur_pc + {{11{off[20]}}, off},
               1'b1, 1'b0);
    run_inst({off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL});
  endtask

  task automatic jalr_check(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
    word_t target;
    target = (model_regs[rs1] + {{20{imm[11]}}, imm}) & ~32'd1; // Low bit cleared
    set_expect(1'b1, rd, cur_pc + 32'd4, 1'b0, '0, '0, target, 1'b1, 1'b0);
    run_inst({imm, rs1, 3'b000, rd, OPC_JALR});
  endtask

  task automatic branch_check(input logic bne, input reg_addr_t rs1, input reg_addr_t rs2,
                              input logic [12:0] off);
    logic  taken;
    word_t target;
    taken = bne ? (model_regs[rs1] != model_regs[rs2]) : (model_regs[rs1] == model_regs[rs2]);
    target = taken ? cur_pc + {{19{off[12]}}, off} : cur_pc + 32'd4;
    set_expect(1'b0, '0, '0, 1'b0, '0, '0, target, 1'b0, taken);
    run_inst({off[12], off[10:5], rs2, rs1, 2'b00, bne, off[4:1], off[11], OPC_BRANCH});
  endtask

  task automatic csrrw_check(input reg_addr_t rd, input csr_addr_t csr, input reg_addr_t rs1);
    set_expect(1'b1, rd, csr_value(csr), 1'b1, csr, model_regs[rs1], cur_pc + 32'd4,
               1'b0, 1'b0);
    run_inst({csr, rs1, 3'b001, rd, OPC_SYSTEM});
  endtask

  task automatic ecall_check();
    set_expect(1'b0, '0, '0, 1'b1, CSR_MCAUSE, CAUSE_ECALL, model_mtvec, 1'b0, 1'b0);
    run_inst({25'b0, OPC_SYSTEM});
  endtask

  // ====================
  // Stimulus
  initial begin
    logic [31:0] rnd;
    reset = 1'b1;
    inst_valid = 1'b0;
    inst = '0;
    pc = '0;
    commit_ready = 1'b0;
    seed = 32'h6c49e6e8;
    cur_pc = 32'h0000_1000;
    commit_pending = 1'b0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    model_mtvec = '0;
    model_mepc = '0;
    model_mcause = '0;
    model_mscratch = '0;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_word("inst_ready", {31'b0, inst_ready}, 32'd1);
    check_word("commit_valid", {31'b0, commit_valid}, 32'd0);
    check_word("rd_we", {31'b0, rd_we}, 32'd0);
    check_word("csr_we", {31'b0, csr_we}, 32'd0);

    addi_check(5'd1, 5'd0, 12'h123);
    addi_check(5'd2, 5'd0, 12'hffb); // -5
    alu_check(1'b0, 5'd3, 5'd1, 5'd2);
    alu_check(1'b1, 5'd4, 5'd1, 5'd2);
    lui_check(5'd5, 20'habcde);
    addi_check(5'd0, 5'd1, 12'h007); // Dropped write to x0
    alu_check(1'b0, 5'd6, 5'd0, 5'd0);
    jal_check(5'd7, 21'h000010);
    addi_check(5'd8, 5'd0, 12'h045);
    jalr_check(5'd9, 5'd8, 12'h004);
    branch_check(1'b0, 5'd1, 5'd1, 13'h0008);
    branch_check(1'b0, 5'd1, 5'd2, 13'h1ffc);
    branch_check(1'b1, 5'd1, 5'd2, 13'h000c);
    branch_check(1'b1, 5'd3, 5'd3, 13'h0008);
    csrrw_check(5'd10, CSR_MSCRATCH, 5'd1);
    csrrw_check(5'd11, CSR_MSCRATCH, 5'd2);
    addi_check(5'd12, 5'd0, 12'h200);
    csrrw_check(5'd13, CSR_MTVEC, 5'd12);
    ecall_check();
    csrrw_check(5'd14, CSR_MCAUSE, 5'd0);

    for (int n = 0; n < 40; n++) begin
      rnd = $random(seed);
      if (rnd[31]) addi_check(rnd[4:0], rnd[9:5], rnd[21:10]);
      else alu_check(1'b0, rnd[4:0], rnd[9:5], rnd[14:10]);
    end
    release_commit();

    $display("Testbench passed");
    $finish;
  end

endmodule

//--- test/core_backend_props.sv
`timescale 1ns/10ps

module core_backend_props (
  input logic                clock,
  input logic                reset,
  input logic                inst_ready,
  input logic                commit_ready,
  input logic                commit_valid,
  input core_pkg::word_t     commit_dnpc,
  input logic                commit_jump,
  input logic                commit_branch,
  input core_pkg::reg_addr_t commit_rd,
  input logic                rd_we,
  input core_pkg::reg_addr_t rd_addr,
  input logic                csr_we
);

  // ====================
  // Commit handshake
  commit_held: assert property (@(posedge clock) disable iff (reset)
    commit_valid && !commit_ready |=> commit_valid && $stable(commit_dnpc) &&
      $stable(commit_jump) && $stable(commit_branch) && $stable(commit_rd))
    else $error("commit record changed before commit_ready");

  issue_blocked: assert property (@(posedge clock) disable iff (reset)
    commit_valid |-> !inst_ready)
    else $error("inst_ready high while a commit is pending");

  // ====================
  // Write strobes
  rd_we_single: assert property (@(posedge clock) disable iff (reset)
    rd_we |=> !rd_we)
    else $error("rd_we held for more than one cycle");

  csr_we_single: assert property (@(posedge clock) disable iff (reset)
    csr_we |=> !csr_we)
    else $error("csr_we held for more than one cycle");

  no_x0_write: assert property (@(posedge clock) disable iff (reset)
    rd_we |-> rd_addr != '0)
    else $error("register write aimed at x0");

endmodule

bind core_backend core_backend_props props_i (.*);

//--- logic/core_backend.sv
`timescale 1ns/10ps

module core_backend (
  input  logic                clock,
  input  logic                reset,
  input  logic                inst_valid,
  input  core_pkg::word_t     inst,
  input  core_pkg::word_t     pc,
  output logic                inst_ready,
  input  logic                commit_ready,
  output logic                commit_valid,
  output core_pkg::word_t     commit_dnpc,
  output logic                commit_jump,
  output logic                commit_branch,
  output core_pkg::reg_addr_t commit_rd,
  output logic                rd_we,
  output core_pkg::reg_addr_t rd_addr,
  output core_pkg::word_t     rd_data,
  output logic                csr_we,
  output core_pkg::csr_addr_t csr_waddr,
  output core_pkg::word_t     csr_wdata
);
  import core_pkg::*;

  // ====================
  // Decode to execute
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      dec_valid;
  op_t       op;
  reg_addr_t rd;
  word_t     rs1_val;
  word_t     rs2_val;
  word_t     imm;
  word_t     dec_pc;
  csr_addr_t csr_addr;
  csr_addr_t csr_raddr;
  word_t     csr_rdata;
  word_t     mtvec;

  // ====================
  // Execute to writeback
  logic      ex_valid;
  reg_addr_t ex_rd;
  logic      ex_wb;
  word_t     ex_result;
  logic      ex_csr_we;
  csr_addr_t ex_csr_addr;
  word_t     ex_csr_wdata;
  word_t     ex_dnpc;
  logic      ex_jump;
  logic      ex_branch;
  logic      ex_ecall;
  logic      wb_ready;
  logic      commit_done;

  assign commit_done = commit_valid && commit_ready; // Frees decode for the next instruction

  decode_unit    decode_i (.*);
  execute_unit   execute_i (.*);
  writeback_unit writeback_i (.*);
  reg_file       reg_file_i (.*);
  csr_file       csr_file_i (.*);

endmodule

//--- logic/writeback_unit.sv
`timescale 1ns/10ps

module writeback_unit (
  input  logic                clock,
  input  logic                reset,
  input  logic                ex_valid,
  input  core_pkg::reg_addr_t ex_rd,
  input  logic                ex_wb,
  input  core_pkg::word_t     ex_result,
  input  logic                ex_csr_we,
  input  core_pkg::csr_addr_t ex_csr_addr,
  input  core_pkg::word_t     ex_csr_wdata,
  input  core_pkg::word_t     ex_dnpc,
  input  logic                ex_jump,
  input  logic                ex_branch,
  input  logic                ex_ecall,
  output logic                wb_ready,
  output core_pkg::reg_addr_t rd_addr,
  output core_pkg::word_t     rd_data,
  output logic                rd_we,
  output logic                csr_we,
  output core_pkg::csr_addr_t csr_waddr,
  output core_pkg::word_t     csr_wdata,
  input  logic                commit_ready,
  output logic                commit_valid,
  output core_pkg::word_t     commit_dnpc,
  output logic                commit_jump,
  output logic                commit_branch,
  output core_pkg::reg_addr_t commit_rd
);
  import core_pkg::*;

  typedef enum logic {
    IDLE,
    HOLD
  } wb_state_t;

  wb_state_t state;
  wb_state_t state_next;
  logic      take;

  assign wb_ready = (state == IDLE);
  assign take = ex_valid && wb_ready;
  assign commit_valid = (state == HOLD);

  // ====================
  // State machine
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    unique case (state)
      IDLE: if (ex_valid) state_next = HOLD;
      HOLD: if (commit_ready) state_next = IDLE; // Record taken by fetch
    endcase
  end

  // ====================
  // Write strobes, one cycle each
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_we <= 1'b0;
      csr_we <= 1'b0;
    end else begin
      rd_we <= take && ex_wb;
      csr_we <= take && (ex_csr_we || ex_ecall);
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      rd_addr <= ex_rd;
      rd_data <= ex_result;
      // ecall records its cause in mcause
      csr_waddr <= ex_ecall ? CSR_MCAUSE : ex_csr_addr;
      csr_wdata <= ex_ecall ? CAUSE_ECALL : ex_csr_wdata;
      commit_dnpc <= ex_dnpc;
      commit_jump <= ex_jump;
      commit_branch <= ex_branch;
      commit_rd <= ex_wb ? ex_rd : '0;
    end
  end

endmodule

//--- logic/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
  input  logic                clock,
  input  logic                reset,
  input  logic                dec_valid,
  input  core_pkg::op_t       op,
  input  core_pkg::reg_addr_t rd,
  input  core_pkg::word_t     rs1_val,
  input  core_pkg::word_t     rs2_val,
  input  core_pkg::word_t     imm,
  input  core_pkg::word_t     dec_pc,
  input  core_pkg::csr_addr_t csr_addr,
  input  core_pkg::word_t     csr_rdata,
  input  core_pkg::word_t     mtvec,
  output core_pkg::csr_addr_t csr_raddr,
  output logic                ex_valid,
  output core_pkg::reg_addr_t ex_rd,
  output logic                ex_wb,
  output core_pkg::word_t     ex_result,
  output logic                ex_csr_we,
  output core_pkg::csr_addr_t ex_csr_addr,
  output core_pkg::word_t     ex_csr_wdata,
  output core_pkg::word_t     ex_dnpc,
  output logic                ex_jump,
  output logic                ex_branch,
  output logic                ex_ecall
);
  import core_pkg::*;

  word_t link;
  word_t sum_imm; // Shared by addi and jalr
  word_t result;
  word_t dnpc;
  logic  writes;
  logic  taken;

  assign csr_raddr = csr_addr;
  assign link = dec_pc + 32'd4;
  assign sum_imm = rs1_val + imm;

  always_comb begin
    result = link;
    dnpc = link;
    writes = 1'b0;
    taken = 1'b0;
    case (op)
      OP_ADDI: begin
        result = sum_imm;
        writes = 1'b1;
      end
      OP_ADD: begin
        result = rs1_val + rs2_val;
        writes = 1'b1;
      end
      OP_SUB: begin
        result = rs1_val - rs2_val;
        writes = 1'b1;
      end
      OP_LUI: begin
        result = imm;
        writes = 1'b1;
      end
      OP_JAL: begin
        dnpc = dec_pc + imm;
        writes = 1'b1;
      end
      OP_JALR: begin
        dnpc = sum_imm & ~32'd1;
        writes = 1'b1;
      end
      OP_BEQ: taken = (rs1_val == rs2_val);
      OP_BNE: taken = (rs1_val != rs2_val);
      OP_CSRRW: begin
        result = csr_rdata; // Old CSR value goes to rd
        writes = 1'b1;
      end
      OP_ECALL: dnpc = mtvec;
      default: writes = 1'b0;
    endcase
    if (taken) dnpc = dec_pc + imm;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= dec_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (dec_valid) begin
      ex_rd <= rd;
      ex_wb <= writes && (rd != '0); // No write to x0
      ex_result <= result;
      ex_csr_we <= (op == OP_CSRRW);
      ex_csr_addr <= csr_addr;
      ex_csr_wdata <= rs1_val;
      ex_dnpc <= dnpc;
      ex_jump <= (op == OP_JAL) || (op == OP_JALR);
      ex_branch <= taken;
      ex_ecall <= (op == OP_ECALL);
    end
  end

endmodule

//--- logic/decode_unit.sv
`timescale 1ns/10ps

module decode_unit (
  input  logic                clock,
  input  logic                reset,
  input  logic                inst_valid,
  input  core_pkg::word_t     inst,
  input  core_pkg::word_t     pc,
  output logic                inst_ready,
  input  logic                commit_done,
  output core_pkg::reg_addr_t rs1_addr,
  output core_pkg::reg_addr_t rs2_addr,
  input  core_pkg::word_t     rs1_data,
  input  core_pkg::word_t     rs2_data,
  output logic                dec_valid,
  output core_pkg::op_t       op,
  output core_pkg::reg_addr_t rd,
  output core_pkg::word_t     rs1_val,
  output core_pkg::word_t     rs2_val,
  output core_pkg::word_t     imm,
  output core_pkg::word_t     dec_pc,
  output core_pkg::csr_addr_t csr_addr
);
  import core_pkg::*;

  logic       busy;
  logic       accept;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  op_t        op_next;
  word_t      imm_next;

  assign inst_ready = !busy;
  assign accept = inst_valid && !busy;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // Register file is read while the instruction is offered
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  always_comb begin
    op_next = OP_NOP; // Unknown encodings fall through
    imm_next = '0;
    case (opcode)
      OPC_OP_IMM: begin
        imm_next = {{20{inst[31]}}, inst[31:20]};
        if (funct3 == 3'b000) op_next = OP_ADDI;
      end
      OPC_OP: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) op_next = OP_ADD;
        else if (funct3 == 3'b000 && funct7 == 7'b0100000) op_next = OP_SUB;
      end
      OPC_LUI: begin
        imm_next = {inst[31:12], 12'b0};
        op_next = OP_LUI;
      end
      OPC_JAL: begin
        imm_next = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        op_next = OP_JAL;
      end
      OPC_JALR: begin
        imm_next = {{20{inst[31]}}, inst[31:20]};
        if (funct3 == 3'b000) op_next = OP_JALR;
      end
      OPC_BRANCH: begin
        imm_next = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        if (funct3 == 3'b000) op_next = OP_BEQ;
        else if (funct3 == 3'b001) op_next = OP_BNE;
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b001) op_next = OP_CSRRW;
        else if (inst[31:7] == '0) op_next = OP_ECALL;
      end
      default: op_next = OP_NOP;
    endcase
  end

  // Busy from acceptance until the commit is taken
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= accept;
      if (accept) busy <= 1'b1;
      else if (commit_done) busy <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      op <= op_next;
      rd <= inst[11:7];
      rs1_val <= rs1_data;
      rs2_val <= rs2_data;
      imm <= imm_next;
      dec_pc <= pc;
      csr_addr <= inst[31:20];
    end
  end

endmodule

//--- logic/csr_file.sv
`timescale 1ns/10ps

module csr_file (
  input  logic                clock,
  input  logic                reset,
  input  core_pkg::csr_addr_t csr_raddr,
  output core_pkg::word_t     csr_rdata,
  input  logic                csr_we,
  input  core_pkg::csr_addr_t csr_waddr,
  input  core_pkg::word_t     csr_wdata,
  output core_pkg::word_t     mtvec
);
  import core_pkg::*;

  word_t mepc;
  word_t mcause;
  word_t mscratch;

  always_comb begin
    case (csr_raddr)
      CSR_MTVEC:    csr_rdata = mtvec;
      CSR_MEPC:     csr_rdata = mepc;
      CSR_MCAUSE:   csr_rdata = mcause;
      CSR_MSCRATCH: csr_rdata = mscratch;
      default:      csr_rdata = '0; // Unimplemented CSR
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mtvec <= '0;
      mepc <= '0;
      mcause <= '0;
      mscratch <= '0;
    end else if (csr_we) begin
      case (csr_waddr)
        CSR_MTVEC:    mtvec <= csr_wdata;
        CSR_MEPC:     mepc <= csr_wdata;
        CSR_MCAUSE:   mcause <= csr_wdata;
        CSR_MSCRATCH: mscratch <= csr_wdata;
        default:      ;
      endcase
    end
  end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/10ps

module reg_file (
  input  logic                clock,
  input  logic                reset,
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  output core_pkg::word_t     rs1_data,
  output core_pkg::word_t     rs2_data,
  input  core_pkg::reg_addr_t rd_addr,
  input  core_pkg::word_t     rd_data,
  input  logic                rd_we
);
  import core_pkg::*;

  word_t regs [32];

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd_addr != '0) begin // x0 stays zero
      regs[rd_addr] <= rd_data;
    end
  end

endmodule

//--- logic/core_pkg.sv
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] csr_addr_t;

  typedef enum logic [3:0] {
    OP_NOP,
    OP_ADDI,
    OP_ADD,
    OP_SUB,
    OP_LUI,
    OP_JAL,
    OP_JALR,
    OP_BEQ,
    OP_BNE,
    OP_CSRRW,
    OP_ECALL
  } op_t;

  // ====================
  // Opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // ====================
  // Machine CSRs
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;

  localparam word_t CAUSE_ECALL = 32'd11; // Environment call from M-mode

endpackage
